/* Makefile */
TOP := tb_upsizer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/axi_pkg.sv */
`include "upsizer_cfg.svh"

package axi_pkg;

  // Address channel fields
  typedef logic [`UPS_ADDR_W-1:0] addr_t;
  typedef logic [`UPS_ID_W-1:0]   id_t;
  typedef logic [`UPS_LEN_W-1:0]  len_t;

  // log2 of bytes per beat
  typedef logic [2:0]             size_t;

  // FIXED, INCR, WRAP
  typedef logic [1:0]             burst_t;

  // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [1:0]             resp_t;

endpackage

/* common/burst_info_if.sv */
`timescale 1ns/1ps

interface burst_info_if
  import upsizer_pkg::*;
();

  // Write side, from the AR converter
  logic        push;
  burst_info_t push_info;
  logic        full;

  // Read side, from the R packer
  logic        pop;
  burst_info_t pop_info;
  logic        empty;

  modport producer (output push, output push_info, input full);

  modport fifo (
    input  push, input  push_info, output full,
    input  pop,  output pop_info,  output empty
  );

  modport consumer (output pop, input pop_info, input empty);

endinterface

/* common/upsizer_cfg.svh */
`ifndef UPSIZER_CFG_SVH
`define UPSIZER_CFG_SVH

// Data widths on the two sides
`define UPS_WIDE_DATA_W   128
`define UPS_NARROW_DATA_W 32

// AXI field widths
`define UPS_ADDR_W 32
`define UPS_ID_W   3
`define UPS_LEN_W  8

// Narrow words per wide word
`define UPS_LANES 4

// Outstanding read bursts
`define UPS_INFO_DEPTH 4

`endif

/* common/upsizer_pkg.sv */
`include "upsizer_cfg.svh"

package upsizer_pkg;

  // ========================================
  // Data path
  // ========================================
  typedef logic [`UPS_WIDE_DATA_W-1:0]   wide_data_t;
  typedef logic [`UPS_NARROW_DATA_W-1:0] narrow_data_t;

  // Narrow lane inside a wide beat
  typedef logic [$clog2(`UPS_LANES)-1:0] lane_t;

  // ========================================
  // Per-burst information
  // ========================================
  // [1] half-width burst (size 3)
  // [0] starting lane pair
  typedef logic [1:0] burst_info_t;

  // R packer
  typedef enum logic {
    FILL,
    HOLD
  } pack_state_t;

endpackage

/* filelist.f */
+incdir+common
+incdir+tests
common/axi_pkg.sv
common/upsizer_pkg.sv
common/burst_info_if.sv
read_path/ar_channel.sv
read_path/burst_info_fifo.sv
read_path/r_channel.sv
source/upsizer_top.sv
tests/tb_upsizer.sv

/* read_path/ar_channel.sv */
`timescale 1ns/1ps
`include "upsizer_cfg.svh"

module ar_channel
  import axi_pkg::*;
  import upsizer_pkg::*;
(
  input  logic           aclk,
  input  logic           rst_n_i,

  // Wide side
  input  addr_t          m_araddr_i,
  input  id_t            m_arid_i,
  input  len_t           m_arlen_i,
  input  size_t          m_arsize_i,
  input  burst_t         m_arburst_i,
  input  logic           m_arvalid_i,
  output logic           m_arready_o,

  // Narrow side
  output addr_t          s_araddr_o,
  output id_t            s_arid_o,
  output len_t           s_arlen_o,
  output size_t          s_arsize_o,
  output burst_t         s_arburst_o,
  output logic           s_arvalid_o,
  input  logic           s_arready_i,

  burst_info_if.producer info
);

  localparam size_t       FULL_SIZE   = 3'd4;
  localparam size_t       NARROW_SIZE = 3'd2;
  localparam int unsigned HALF_LANES  = `UPS_LANES / 2;

  logic        m_ar_hs;
  logic        half_burst;
  len_t        narrow_len;

  // One narrow request in flight at a time
  assign m_arready_o = !s_arvalid_o && !info.full;
  assign m_ar_hs     = m_arvalid_i && m_arready_o;

  assign half_burst  = (m_arsize_i != FULL_SIZE);

  // Narrow beats = wide beats * narrow words per wide beat
  always_comb begin
    if (half_burst) begin
      narrow_len = len_t'((int'(m_arlen_i) + 1) * HALF_LANES - 1);
    end else begin
      narrow_len = len_t'((int'(m_arlen_i) + 1) * `UPS_LANES - 1);
    end
  end

  // Lane pair of the first beat comes from address bit 3
  assign info.push      = m_ar_hs;
  assign info.push_info = {half_burst, m_araddr_i[3]};

  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      s_arvalid_o <= 1'b0;
    end else if (m_ar_hs) begin
      s_arvalid_o <= 1'b1;
    end else if (s_arready_i) begin
      s_arvalid_o <= 1'b0;
    end
  end

  // Translated request
  always_ff @(posedge aclk) begin
    if (m_ar_hs) begin
      s_araddr_o  <= m_araddr_i;
      s_arid_o    <= m_arid_i;
      s_arlen_o   <= narrow_len;
      s_arburst_o <= m_arburst_i;
    end
  end

  assign s_arsize_o = NARROW_SIZE;

endmodule

/* read_path/burst_info_fifo.sv */
`timescale 1ns/1ps
`include "upsizer_cfg.svh"

module burst_info_fifo
  import upsizer_pkg::*;
(
  input  logic       aclk,
  input  logic       rst_n_i,

  burst_info_if.fifo info
);

  localparam int unsigned DEPTH = `UPS_INFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  burst_info_t       mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              do_push;
  logic              do_pop;

  assign do_push = info.push && !info.full;
  assign do_pop  = info.pop && !info.empty;

  assign info.full     = (count == (PTR_W+1)'(DEPTH));
  assign info.empty    = (count == '0);
  assign info.pop_info = mem[rd_ptr];

  // ========================================
  // Storage
  // ========================================
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= info.push_info;
    end
  end

  // ========================================
  // Pointers and fill level
  // ========================================
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* read_path/r_channel.sv */
`timescale 1ns/1ps
`include "upsizer_cfg.svh"

module r_channel
  import axi_pkg::*;
  import upsizer_pkg::*;
(
  input  logic           aclk,
  input  logic           rst_n_i,

  // Narrow side
  input  id_t            s_rid_i,
  input  narrow_data_t   s_rdata_i,
  input  resp_t          s_rresp_i,
  input  logic           s_rlast_i,
  input  logic           s_rvalid_i,
  output logic           s_rready_o,

  // Wide side
  output id_t            m_rid_o,
  output wide_data_t     m_rdata_o,
  output resp_t          m_rresp_o,
  output logic           m_rlast_o,
  output logic           m_rvalid_o,
  input  logic           m_rready_i,

  burst_info_if.consumer info
);

  localparam int unsigned NARROW_W   = `UPS_NARROW_DATA_W;
  localparam int unsigned HALF_LANES = `UPS_LANES / 2;

  pack_state_t state_q;
  lane_t       lane_q;
  logic        burst_start_q;
  logic        new_beat_q;

  logic        s_hs;
  logic        half;
  lane_t       start_lane;
  lane_t       cur_lane;
  lane_t       next_lane;
  logic        beat_done;
  wide_data_t  data_next;
  resp_t       resp_next;

  assign s_rready_o = (state_q == FILL) && !info.empty;
  assign s_hs       = s_rvalid_i && s_rready_o;
  assign m_rvalid_o = (state_q == HOLD);

  // Burst ends with the narrow rlast
  assign info.pop   = s_hs && s_rlast_i;

  // ========================================
  // Lane placement
  // ========================================
  assign half       = info.pop_info[1];
  assign start_lane = (half && info.pop_info[0]) ? lane_t'(HALF_LANES) : '0;
  assign cur_lane   = burst_start_q ? start_lane : lane_q;

  // Counter wraps, so half bursts alternate pairs on their own
  assign next_lane  = cur_lane + 1'b1;

  always_comb begin
    if (half) begin
      beat_done = ((next_lane % HALF_LANES) == 0) || s_rlast_i;
    end else begin
      beat_done = (next_lane == '0) || s_rlast_i;
    end
  end

  // Fresh wide beat starts from zero, which blanks the unused half
  always_comb begin
    data_next = new_beat_q ? '0 : m_rdata_o;
    data_next[cur_lane*NARROW_W +: NARROW_W] = s_rdata_i;
  end

  // Worst response over the beats of one wide beat
  assign resp_next = (new_beat_q || (s_rresp_i > m_rresp_o)) ? s_rresp_i : m_rresp_o;

  // ========================================
  // Control
  // ========================================
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      state_q       <= FILL;
      lane_q        <= '0;
      burst_start_q <= 1'b1;
      new_beat_q    <= 1'b1;
    end else begin
      case (state_q)
        FILL: begin
          if (s_hs) begin
            new_beat_q <= beat_done;
            if (s_rlast_i) begin
              lane_q        <= '0;
              burst_start_q <= 1'b1;
            end else begin
              lane_q        <= next_lane;
              burst_start_q <= 1'b0;
            end
            if (beat_done) begin
              state_q <= HOLD;
            end
          end
        end
        HOLD: begin
          if (m_rready_i) begin
            state_q <= FILL;
          end
        end
        default: state_q <= FILL;
      endcase
    end
  end

  // Wide beat, frozen while in HOLD
  always_ff @(posedge aclk) begin
    if (s_hs) begin
      m_rdata_o <= data_next;
      m_rresp_o <= resp_next;
      m_rid_o   <= s_rid_i;
      m_rlast_o <= s_rlast_i;
    end
  end

endmodule

/* source/upsizer_top.sv */
`timescale 1ns/1ps

module upsizer_top
  import axi_pkg::*;
  import upsizer_pkg::*;
(
  input  logic         aclk,
  input  logic         rst_n_i,

  // Wide read address
  input  addr_t        m_araddr_i,
  input  id_t          m_arid_i,
  input  len_t         m_arlen_i,
  input  size_t        m_arsize_i,
  input  burst_t       m_arburst_i,
  input  logic         m_arvalid_i,
  output logic         m_arready_o,

  // Narrow read address
  output addr_t        s_araddr_o,
  output id_t          s_arid_o,
  output len_t         s_arlen_o,
  output size_t        s_arsize_o,
  output burst_t       s_arburst_o,
  output logic         s_arvalid_o,
  input  logic         s_arready_i,

  // Narrow read data
  input  id_t          s_rid_i,
  input  narrow_data_t s_rdata_i,
  input  resp_t        s_rresp_i,
  input  logic         s_rlast_i,
  input  logic         s_rvalid_i,
  output logic         s_rready_o,

  // Wide read data
  output id_t          m_rid_o,
  output wide_data_t   m_rdata_o,
  output resp_t        m_rresp_o,
  output logic         m_rlast_o,
  output logic         m_rvalid_o,
  input  logic         m_rready_i
);

  burst_info_if info_if ();

  ar_channel u_ar_channel (
    .aclk        (aclk),
    .rst_n_i     (rst_n_i),
    .m_araddr_i  (m_araddr_i),
    .m_arid_i    (m_arid_i),
    .m_arlen_i   (m_arlen_i),
    .m_arsize_i  (m_arsize_i),
    .m_arburst_i (m_arburst_i),
    .m_arvalid_i (m_arvalid_i),
    .m_arready_o (m_arready_o),
    .s_araddr_o  (s_araddr_o),
    .s_arid_o    (s_arid_o),
    .s_arlen_o   (s_arlen_o),
    .s_arsize_o  (s_arsize_o),
    .s_arburst_o (s_arburst_o),
    .s_arvalid_o (s_arvalid_o),
    .s_arready_i (s_arready_i),
    .info        (info_if.producer)
  );

  burst_info_fifo u_burst_info_fifo (
    .aclk    (aclk),
    .rst_n_i (rst_n_i),
    .info    (info_if.fifo)
  );

  r_channel u_r_channel (
    .aclk       (aclk),
    .rst_n_i    (rst_n_i),
    .s_rid_i    (s_rid_i),
    .s_rdata_i  (s_rdata_i),
    .s_rresp_i  (s_rresp_i),
    .s_rlast_i  (s_rlast_i),
    .s_rvalid_i (s_rvalid_i),
    .s_rready_o (s_rready_o),
    .m_rid_o    (m_rid_o),
    .m_rdata_o  (m_rdata_o),
    .m_rresp_o  (m_rresp_o),
    .m_rlast_o  (m_rlast_o),
    .m_rvalid_o (m_rvalid_o),
    .m_rready_i (m_rready_i),
    .info       (info_if.consumer)
  );

endmodule

/* tests/tb_upsizer_tasks.svh */
`ifndef TB_UPSIZER_TASKS_SVH
`define TB_UPSIZER_TASKS_SVH

typedef struct packed {
  addr_t addr;
  id_t   id;
  len_t  len;
  size_t size;
} read_req_t;

typedef struct packed {
  wide_data_t data;
  resp_t      resp;
  id_t        id;
  logic       last;
} wide_beat_t;

// Accepted on the wide side, then answered by the narrow slave
read_req_t  pending_reqs[$];
read_req_t  granted_reqs[$];
wide_beat_t expected_beats[$];

task automatic abort_run(input string reason);
  $display("%s", reason);
  $display("TEST FAIL");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
  if (actual !== expected) begin
    abort_run($sformatf("FAIL at %0d ns: %s got 0x%0h, expected 0x%0h",
                        $time, name, actual, expected));
  end
endtask

// 16-byte beats take four narrow words, 8-byte beats two
function automatic int beats_per_wide(input size_t size);
  return (size == 3'd4) ? 4 : 2;
endfunction

task automatic drive_wide_ar(input addr_t addr, input id_t id, input len_t len,
                             input size_t size);
  @(posedge aclk);
  #1;
  m_araddr_i  = addr;
  m_arid_i    = id;
  m_arlen_i   = len;
  m_arsize_i  = size;
  m_arburst_i = 2'b01;
  m_arvalid_i = 1'b1;
  do @(posedge aclk); while (!m_arready_o);
  pending_reqs.push_back({addr, id, len, size});
  #1 m_arvalid_i = 1'b0;
endtask

task automatic accept_narrow_ar(input int hold);
  read_req_t req;
  len_t      exp_len;
  do @(posedge aclk); while (!s_arvalid_o);
  if (pending_reqs.size() == 0) begin
    abort_run("Narrow AR request appeared without an accepted wide request");
  end
  req     = pending_reqs.pop_front();
  exp_len = len_t'((int'(req.len) + 1) * beats_per_wide(req.size) - 1);
  check_value("s_araddr_o", s_araddr_o, req.addr);
  check_value("s_arid_o", s_arid_o, req.id);
  check_value("s_arlen_o", s_arlen_o, exp_len);
  check_value("s_arsize_o", s_arsize_o, 3'd2);
  check_value("s_arburst_o", s_arburst_o, 2'b01);
  // Stalled narrow AR keeps its fields and blocks the wide side
  repeat (hold) begin
    @(posedge aclk);
    check_value("s_arvalid_o", s_arvalid_o, 1'b1);
    check_value("s_araddr_o", s_araddr_o, req.addr);
    check_value("s_arid_o", s_arid_o, req.id);
    check_value("s_arlen_o", s_arlen_o, exp_len);
    check_value("m_arready_o", m_arready_o, 1'b0);
  end
  #1 s_arready_i = 1'b1;
  @(posedge aclk);
  #1 s_arready_i = 1'b0;
  granted_reqs.push_back(req);
endtask

task automatic send_narrow_burst();
  read_req_t    req;
  wide_beat_t   beat;
  narrow_data_t word;
  resp_t        resp;
  int           per_wide;
  int           total;
  int           lane;
  if (granted_reqs.size() == 0) begin
    abort_run("Narrow slave has no accepted request to answer");
  end
  req      = granted_reqs.pop_front();
  per_wide = beats_per_wide(req.size);
  total    = (int'(req.len) + 1) * per_wide;
  beat     = '0;
  @(posedge aclk);
  #1;
  for (int i = 0; i < total; i++) begin
    word = $urandom;
    resp = resp_t'($urandom % 4);
    // Half bursts alternate lane pairs, starting from address bit 3
    if (per_wide == 4) begin
      lane = i % 4;
    end else begin
      lane = 2 * ((int'(req.addr[3]) + i / 2) % 2) + i % 2;
    end
    beat.data[lane*`UPS_NARROW_DATA_W +: `UPS_NARROW_DATA_W] = word;
    if (resp > beat.resp) begin
      beat.resp = resp;
    end
    s_rvalid_i = 1'b1;
    s_rid_i    = req.id;
    s_rdata_i  = word;
    s_rresp_i  = resp;
    s_rlast_i  = (i == total - 1);
    do @(posedge aclk); while (!s_rready_o);
    if ((i % per_wide) == per_wide - 1) begin
      beat.id   = req.id;
      beat.last = (i == total - 1);
      expected_beats.push_back(beat);
      beat = '0;
    end
    #1;
  end
  s_rvalid_i = 1'b0;
  s_rlast_i  = 1'b0;
endtask

task automatic verify_wide_beat(input wide_beat_t exp);
  check_value("m_rdata_o", m_rdata_o, exp.data);
  check_value("m_rresp_o", m_rresp_o, exp.resp);
  check_value("m_rid_o", m_rid_o, exp.id);
  check_value("m_rlast_o", m_rlast_o, exp.last);
endtask

task automatic collect_wide_beats(input int count, input int stall);
  wide_beat_t exp;
  @(posedge aclk);
  #1 m_rready_i = (stall == 0);
  for (int n = 0; n < count; n++) begin
    do @(posedge aclk); while (!m_rvalid_o);
    if (expected_beats.size() == 0) begin
      abort_run("Wide read beat arrived when none was expected");
    end
    exp = expected_beats.pop_front();
    verify_wide_beat(exp);
    if (stall > 0) begin
      // Stalled wide beat keeps its fields until m_rready_i
      repeat (stall) begin
        @(posedge aclk);
        check_value("m_rvalid_o", m_rvalid_o, 1'b1);
        verify_wide_beat(exp);
      end
      #1 m_rready_i = 1'b1;
      @(posedge aclk);
      check_value("m_rvalid_o", m_rvalid_o, 1'b1);
      verify_wide_beat(exp);
      #1 m_rready_i = 1'b0;
    end
  end
endtask

`endif

/* tests/tb_upsizer.sv */
`timescale 1ns/1ps
`include "upsizer_cfg.svh"

module tb_upsizer
  import axi_pkg::*;
  import upsizer_pkg::*;
();

  // Each test takes well under a hundred cycles
  localparam int MAX_CYCLES = 2000;

  logic         aclk;
  logic         rst_n_i;
  addr_t        m_araddr_i;
  id_t          m_arid_i;
  len_t         m_arlen_i;
  size_t        m_arsize_i;
  burst_t       m_arburst_i;
  logic         m_arvalid_i;
  logic         m_arready_o;
  addr_t        s_araddr_o;
  id_t          s_arid_o;
  len_t         s_arlen_o;
  size_t        s_arsize_o;
  burst_t       s_arburst_o;
  logic         s_arvalid_o;
  logic         s_arready_i;
  id_t          s_rid_i;
  narrow_data_t s_rdata_i;
  resp_t        s_rresp_i;
  logic         s_rlast_i;
  logic         s_rvalid_i;
  logic         s_rready_o;
  id_t          m_rid_o;
  wide_data_t   m_rdata_o;
  resp_t        m_rresp_o;
  logic         m_rlast_o;
  logic         m_rvalid_o;
  logic         m_rready_i;
  int           cycle_count = 0;

  `include "tb_upsizer_tasks.svh"

  upsizer_top dut (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout: tests did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // ========================================
  // Tests
  // ========================================
  task automatic run_burst(input addr_t addr, input id_t id, input len_t len,
                           input size_t size);
    fork
      drive_wide_ar(addr, id, len, size);
      begin
        accept_narrow_ar(0);
        send_narrow_burst();
      end
      collect_wide_beats(int'(len) + 1, 0);
    join
  endtask

  task automatic test_single_beat();
    @(posedge aclk);
    check_value("s_arvalid_o", s_arvalid_o, 1'b0);
    check_value("m_rvalid_o", m_rvalid_o, 1'b0);
    check_value("m_arready_o", m_arready_o, 1'b1);
    check_value("s_rready_o", s_rready_o, 1'b0);
    run_burst(32'h0000_1000, 3'd5, 8'd0, 3'd4);
  endtask

  task automatic test_back_pressure();
    // Second wide request waits behind a stalled narrow AR
    fork
      begin
        drive_wide_ar(32'h0000_4000, 3'd3, 8'd1, 3'd4);
        drive_wide_ar(32'h0000_4108, 3'd4, 8'd1, 3'd3);
      end
      begin
        accept_narrow_ar(6);
        send_narrow_burst();
        accept_narrow_ar(0);
        send_narrow_burst();
      end
      collect_wide_beats(4, 3);
    join
  endtask

  task automatic test_two_outstanding();
    fork
      begin
        drive_wide_ar(32'h0000_5000, 3'd6, 8'd1, 3'd4);
        drive_wide_ar(32'h0000_5200, 3'd1, 8'd2, 3'd3);
      end
      begin
        accept_narrow_ar(0);
        accept_narrow_ar(0);
      end
    join
    fork
      begin
        send_narrow_burst();
        send_narrow_burst();
      end
      collect_wide_beats(5, 0);
    join
  endtask

  initial begin
    void'($urandom(32'h8d86_f18a));
    rst_n_i     = 1'b0;
    m_araddr_i  = '0;
    m_arid_i    = '0;
    m_arlen_i   = '0;
    m_arsize_i  = '0;
    m_arburst_i = '0;
    m_arvalid_i = 1'b0;
    s_arready_i = 1'b0;
    s_rid_i     = '0;
    s_rdata_i   = '0;
    s_rresp_i   = '0;
    s_rlast_i   = 1'b0;
    s_rvalid_i  = 1'b0;
    m_rready_i  = 1'b0;
    repeat (8) @(posedge aclk);
    #1 rst_n_i = 1'b1;

    test_single_beat();
    run_burst(32'h0000_2040, 3'd2, 8'd3, 3'd4);
    // Half-width burst starting on the upper lane pair
    run_burst(32'h0000_3008, 3'd1, 8'd3, 3'd3);
    test_back_pressure();
    test_two_outstanding();

    $display("TEST PASS");
    $finish;
  end

endmodule
